// File: files.f
hdl/sdp_pkg.sv
hdl/sdp_port_if.sv
hdl/sdp_ram.sv
hdl/word_writer.sv
hdl/pair_reader.sv
hdl/width_fifo_top.sv
sim/tb_width_fifo.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the width-converting FIFO testbench with Verilator and runs it.
# The exit status is 0 only when the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
        -f files.f \
        --top-module tb_width_fifo \
        -o tb_width_fifo_sim
build_status=$?
if [ $build_status -ne 0 ]; then
        echo "Verilator build failed with status $build_status"
        exit 1
fi

sim_output=$(./obj_dir/tb_width_fifo_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
        echo "Simulation exited with status $sim_status"
        exit 1
fi

if echo "$sim_output" | grep -qx "=== PASS ==="; then
        echo "Simulation passed"
        exit 0
fi

echo "Simulation did not report a pass"
exit 1

// File: sim/tb_width_fifo.sv
`timescale 1ns/1ps

module tb_width_fifo;

        //////////////////////////////////////////////////////////////////////
        // Constants and DUT signals
        //////////////////////////////////////////////////////////////////////

        localparam int          CLK_PERIOD    = 4;              // In ns
        localparam int          RESET_CYCLES  = 16;
        localparam int unsigned RAND_SEED     = 32'ha2af7dab;
        localparam int          WAIT_LIMIT    = 50;             // Longest any single wait may take
        localparam int          RANDOM_CYCLES = 2000;

        logic                   clk;
        logic                   reset;
        logic                   in_valid;
        sdp_pkg::wr_word_t      in_data;
        logic                   out_req;
        sdp_pkg::rd_word_t      out_data;
        logic                   out_valid;
        logic                   overflow;
        logic                   underflow;
        sdp_pkg::level_t        level;

        // Reference model, oldest word at the front
        sdp_pkg::wr_word_t      model_q [$];
        sdp_pkg::rd_word_t      held_data;              // Last entry read, zero after reset

        int                     error_count;
        int                     check_count;
        int                     words_accepted;
        int                     pops_served;
        int unsigned            seed_value;

        width_fifo_top dut_i (
                .clk       (clk),
                .reset     (reset),
                .in_valid  (in_valid),
                .in_data   (in_data),
                .out_req   (out_req),
                .out_data  (out_data),
                .out_valid (out_valid),
                .overflow  (overflow),
                .underflow (underflow),
                .level     (level)
        );

        initial begin
                clk = 1'b0;
                forever begin
                        #(CLK_PERIOD / 2) clk = ~clk;
                end
        end

        //////////////////////////////////////////////////////////////////////
        // Cycle driver and output comparison
        //////////////////////////////////////////////////////////////////////

        // Every output is compared on the falling edge after the rising edge
        // that produced it, where nothing is changing
        task automatic compare_outputs(input logic exp_valid, input logic exp_overflow,
                                       input logic exp_underflow);
                check_count++;
                if (out_valid !== exp_valid) begin
                        $display("Fail at %0t ns: out_valid expected %0b, got %0b",
                                 $time, exp_valid, out_valid);
                        error_count++;
                end
                if (out_data !== held_data) begin                // Fresh or held entry
                        $display("Fail at %0t ns: out_data expected %h, got %h",
                                 $time, held_data, out_data);
                        error_count++;
                end
                if (overflow !== exp_overflow) begin
                        $display("Fail at %0t ns: overflow expected %0b, got %0b",
                                 $time, exp_overflow, overflow);
                        error_count++;
                end
                if (underflow !== exp_underflow) begin
                        $display("Fail at %0t ns: underflow expected %0b, got %0b",
                                 $time, exp_underflow, underflow);
                        error_count++;
                end
                if (level !== sdp_pkg::level_t'(model_q.size())) begin
                        $display("Fail at %0t ns: level expected %0d, got %0d",
                                 $time, model_q.size(), level);
                        error_count++;
                end
        endtask

        // One clock cycle of traffic, entered and left on a falling edge
        task automatic run_cycle(input logic push, input sdp_pkg::wr_word_t word,
                                 input logic pop);
                int                     count_before;
                logic                   push_ok;
                logic                   pop_ok;
                sdp_pkg::wr_word_t      low_word;
                sdp_pkg::wr_word_t      high_word;
                count_before = model_q.size();                  // Both judged on this count
                push_ok      = push && (count_before < sdp_pkg::DEPTH_WORDS);
                pop_ok       = pop && (count_before >= 2);
                in_valid = push;
                in_data  = word;
                out_req  = pop;
                @(posedge clk);
                @(negedge clk);
                in_valid = 1'b0;
                out_req  = 1'b0;
                // The pop takes the two oldest words, so it goes before the push
                if (pop_ok) begin
                        low_word  = model_q.pop_front();
                        high_word = model_q.pop_front();
                        held_data = {high_word, low_word};      // Older word in the low half
                        pops_served++;
                end
                if (push_ok) begin
                        model_q.push_back(word);
                        words_accepted++;
                end
                compare_outputs(pop_ok, push && !push_ok, pop && !pop_ok);
        endtask

        // Idles until level shows the wanted count
        task automatic wait_level(input int target);
                int cycles;
                cycles = 0;
                while (level !== sdp_pkg::level_t'(target) && cycles < WAIT_LIMIT) begin
                        run_cycle(1'b0, '0, 1'b0);
                        cycles++;
                end
                if (level !== sdp_pkg::level_t'(target)) begin
                        $display("Timeout: level did not reach %0d within %0d cycles",
                                 target, WAIT_LIMIT);
                        error_count++;
                end
        endtask

        //////////////////////////////////////////////////////////////////////
        // Directed tests
        //////////////////////////////////////////////////////////////////////

        task automatic check_reset_state();
                check_count++;
                if (out_valid !== 1'b0) begin
                        $display("Fail at %0t ns: out_valid expected 0, got %0b",
                                 $time, out_valid);
                        error_count++;
                end
                if (overflow !== 1'b0) begin
                        $display("Fail at %0t ns: overflow expected 0, got %0b",
                                 $time, overflow);
                        error_count++;
                end
                if (underflow !== 1'b0) begin
                        $display("Fail at %0t ns: underflow expected 0, got %0b",
                                 $time, underflow);
                        error_count++;
                end
                if (level !== '0) begin
                        $display("Fail at %0t ns: level expected 0, got %0d", $time, level);
                        error_count++;
                end
        endtask

        // Two known words, then a pop whose latency is measured by hand
        task automatic test_single_pair();
                sdp_pkg::wr_word_t      first;
                sdp_pkg::wr_word_t      second;
                sdp_pkg::wr_word_t      discard;
                int                     cycles;
                first  = 32'h0123_4567;
                second = 32'h89ab_cdef;
                run_cycle(1'b1, first, 1'b0);
                run_cycle(1'b1, second, 1'b0);
                out_req = 1'b1;
                cycles  = 0;
                do begin
                        @(posedge clk);
                        @(negedge clk);
                        out_req = 1'b0;                         // A request lasts one cycle
                        cycles++;
                end while (out_valid !== 1'b1 && cycles < WAIT_LIMIT);
                discard   = model_q.pop_front();
                discard   = model_q.pop_front();
                held_data = {second, first};
                pops_served++;
                check_count++;
                if (out_valid !== 1'b1) begin
                        $display("Timeout: out_valid did not rise within %0d cycles of a pop",
                                 WAIT_LIMIT);
                        error_count++;
                end else if (cycles != 1) begin
                        $display("Fail at %0t ns: out_valid latency expected 1, got %0d",
                                 $time, cycles);
                        error_count++;
                end
                if (out_data !== held_data) begin
                        $display("Fail at %0t ns: out_data expected %h, got %h",
                                 $time, held_data, out_data);
                        error_count++;
                end
                if (level !== '0) begin
                        $display("Fail at %0t ns: level expected 0, got %0d", $time, level);
                        error_count++;
                end
        endtask

        // A lone word is no entry yet; the pop is refused until its partner arrives
        task automatic test_underflow_then_pair();
                run_cycle(1'b1, 32'hcafe_0001, 1'b0);
                run_cycle(1'b0, '0, 1'b1);                      // Refused, underflow next cycle
                run_cycle(1'b0, '0, 1'b0);                      // No late out_valid may follow
                run_cycle(1'b1, 32'hcafe_0002, 1'b0);
                run_cycle(1'b0, '0, 1'b1);
                wait_level(0);
        endtask

        // Fill to the brim, push once more, then drain every entry
        task automatic test_full_overflow();
                int i;
                for (i = model_q.size(); i < sdp_pkg::DEPTH_WORDS; i++) begin
                        run_cycle(1'b1, $urandom, 1'b0);
                end
                wait_level(sdp_pkg::DEPTH_WORDS);
                run_cycle(1'b1, $urandom, 1'b0);                // Dropped, overflow expected
                for (i = 0; i < sdp_pkg::DEPTH_WORDS / 2; i++) begin
                        run_cycle(1'b0, '0, 1'b1);
                end
                wait_level(0);
        endtask

        // Three phases of mixed traffic: filling, draining down to empty,
        // then nearly balanced, so both pointers pass their wrap points
        task automatic test_random_traffic();
                int     cycle;
                int     push_pct;
                int     pop_pct;
                logic   push;
                logic   pop;
                for (cycle = 0; cycle < RANDOM_CYCLES; cycle++) begin
                        if (cycle < 600) begin
                                push_pct = 94;
                                pop_pct  = 25;
                        end else if (cycle < 1200) begin
                                push_pct = 50;
                                pop_pct  = 50;
                        end else begin
                                push_pct = 94;
                                pop_pct  = 44;
                        end
                        push = ($urandom % 100) < push_pct;
                        pop  = ($urandom % 100) < pop_pct;
                        run_cycle(push, $urandom, pop);
                end
                $display("Traffic so far: %0d words accepted, %0d entries popped",
                         words_accepted, pops_served);
                // The write pointer spans 2048 words and the read pointer 1024 entries
                check_count++;
                if (words_accepted < 2 * sdp_pkg::DEPTH_WORDS ||
                    pops_served < sdp_pkg::DEPTH_WORDS) begin
                        $display("Random traffic did not carry both pointers past their wrap");
                        error_count++;
                end
        endtask

        //////////////////////////////////////////////////////////////////////
        // Sequence
        //////////////////////////////////////////////////////////////////////

        initial begin
                error_count    = 0;
                check_count    = 0;
                words_accepted = 0;
                pops_served    = 0;
                held_data      = '0;
                seed_value     = $urandom(RAND_SEED);           // Seeds the generator once
                reset    = 1'b1;
                in_valid = 1'b0;
                in_data  = '0;
                out_req  = 1'b0;
                repeat (RESET_CYCLES) @(posedge clk);
                @(negedge clk);
                reset = 1'b0;

                check_reset_state();
                test_single_pair();
                test_underflow_then_pair();
                test_full_overflow();
                test_random_traffic();

                $display("Checks: %0d, errors: %0d", check_count, error_count);
                if (error_count == 0) begin
                        $display("=== PASS ===");
                end else begin
                        $display("=== FAIL ===");
                end
                $finish;
        end

endmodule

// File: hdl/width_fifo_top.sv
`timescale 1ns/1ps

module width_fifo_top (
        input  logic                    clk,
        input  logic                    reset,

        // Producer side, 32-bit words
        input  logic                    in_valid,
        input  sdp_pkg::wr_word_t       in_data,

        // Consumer side, 64-bit entries of two words
        input  logic                    out_req,
        output sdp_pkg::rd_word_t       out_data,
        output logic                    out_valid,

        // Status
        output logic                    overflow,       // A word was dropped
        output logic                    underflow,      // A request was refused
        output sdp_pkg::level_t         level           // Words stored
);

        //////////////////////////////////////////////////////////////////////
        // Internal connections
        //////////////////////////////////////////////////////////////////////

        sdp_port_if             mem_if ();              // Both ports of the array

        sdp_pkg::wr_ptr_t       wr_ptr;                 // Writer to reader, for emptiness
        sdp_pkg::rd_ptr_t       rd_ptr;                 // Reader to writer, for fullness

        //////////////////////////////////////////////////////////////////////
        // Blocks
        //////////////////////////////////////////////////////////////////////

        // Owns the write pointer, the level and the overflow strobe
        word_writer writer_i (
                .clk       (clk),
                .reset     (reset),
                .in_valid  (in_valid),
                .in_data   (in_data),
                .rd_ptr    (rd_ptr),
                .port      (mem_if.wr),
                .wr_ptr    (wr_ptr),
                .level     (level),
                .overflow  (overflow)
        );

        // Owns the read pointer and the output strobes
        pair_reader reader_i (
                .clk       (clk),
                .reset     (reset),
                .out_req   (out_req),
                .wr_ptr    (wr_ptr),
                .port      (mem_if.rd),
                .rd_ptr    (rd_ptr),
                .out_data  (out_data),
                .out_valid (out_valid),
                .underflow (underflow)
        );

        // Single clock for both ports, read-first on a collision
        sdp_ram ram_i (
                .clk       (clk),
                .reset     (reset),
                .port      (mem_if.mem)
        );

endmodule

// File: hdl/pair_reader.sv
`timescale 1ns/1ps

module pair_reader (
        input  logic                    clk,
        input  logic                    reset,
        input  logic                    out_req,        // Request for one entry
        input  sdp_pkg::wr_ptr_t        wr_ptr,         // Words written so far
        sdp_port_if.rd                  port,
        output sdp_pkg::rd_ptr_t        rd_ptr,         // Entries taken so far, with wrap bit
        output sdp_pkg::rd_word_t       out_data,
        output logic                    out_valid,      // out_data holds a fresh entry
        output logic                    underflow       // Pulses after a refused request
);

        //////////////////////////////////////////////////////////////////////
        // Pair availability
        //////////////////////////////////////////////////////////////////////

        sdp_pkg::rd_ptr_t       wr_pairs;               // Complete entries written so far
        sdp_pkg::rd_ptr_t       pairs;                  // Complete entries waiting to be read
        logic                   pair_ok;                // At least one entry can be popped
        logic                   pop_ok;                 // This request will be served

        // Dropping the low bit of the word pointer counts finished entries.
        // A lone odd word is not visible to the reader
        assign wr_pairs = wr_ptr[sdp_pkg::WR_ADDR_W:1];

        // Both values wrap at 1024, so the difference survives wraps and
        // reaches at most 512 when the array is full
        assign pairs = wr_pairs - rd_ptr;

        assign pair_ok = (pairs != '0);                 // Two or more words stored

        // Judged on the pointers before the edge, so a word pushed in the
        // same cycle never completes a pair for this request
        assign pop_ok = out_req & pair_ok;

        //////////////////////////////////////////////////////////////////////
        // Memory read port
        //////////////////////////////////////////////////////////////////////

        // The read is issued in the request cycle itself
        assign port.re    = pop_ok;
        assign port.raddr = rd_ptr[sdp_pkg::RD_ADDR_W-1:0];     // Entry without wrap bit

        // The memory latch already holds the entry one cycle after re.
        // out_valid marks the cycle in which it is new
        assign out_data = port.rdata;

        //////////////////////////////////////////////////////////////////////
        // Pointer and status
        //////////////////////////////////////////////////////////////////////

        always_ff @(posedge clk) begin
                if (reset) begin
                        rd_ptr    <= '0;
                        out_valid <= 1'b0;
                        underflow <= 1'b0;
                end else begin
                        if (pop_ok) begin
                                rd_ptr <= rd_ptr + 1'b1;        // Next entry to read
                        end

                        // Delayed by one cycle so that it lines up with rdata
                        out_valid <= pop_ok;

                        // A request with less than a pair stored is ignored.
                        // The next cycle says so for one cycle
                        underflow <= out_req & ~pair_ok;
                end
        end

        // The writer sees the advanced rd_ptr on the next cycle, which is
        // when the level drops by two

endmodule

// File: hdl/word_writer.sv
`timescale 1ns/1ps

module word_writer (
        input  logic                    clk,
        input  logic                    reset,
        input  logic                    in_valid,       // One word offered this cycle
        input  sdp_pkg::wr_word_t       in_data,
        input  sdp_pkg::rd_ptr_t        rd_ptr,         // Entries already taken by the reader
        sdp_port_if.wr                  port,
        output sdp_pkg::wr_ptr_t        wr_ptr,         // Words written so far, with wrap bit
        output sdp_pkg::level_t         level,          // Words currently stored
        output logic                    overflow        // Pulses after a dropped word
);

        //////////////////////////////////////////////////////////////////////
        // Fill count
        //////////////////////////////////////////////////////////////////////

        sdp_pkg::wr_ptr_t       rd_word_ptr;            // Read pointer scaled to words
        sdp_pkg::level_t        count;                  // Words between the two pointers
        logic                   full;
        logic                   push_ok;                // The offered word will be stored

        // Each entry the reader removes is two words, so its pointer is
        // doubled before the comparison
        assign rd_word_ptr = {rd_ptr, 1'b0};

        // Both pointers wrap at the same modulus, so a plain difference
        // gives the count across any number of wraps
        assign count = wr_ptr - rd_word_ptr;

        // Both pointers are registers, so the count moves one cycle after
        // an accepted push or pop and is exported as the level
        assign level = count;

        // Full means the extra bit differs and the word address bits match
        assign full = (count == sdp_pkg::level_t'(sdp_pkg::DEPTH_WORDS));

        // A pop in the same cycle does not free room for this push.
        // Both are judged on the count before the edge
        assign push_ok = in_valid & ~full;

        //////////////////////////////////////////////////////////////////////
        // Memory write port
        //////////////////////////////////////////////////////////////////////

        // The write goes out in the same cycle as the offer
        assign port.we    = push_ok;
        assign port.waddr = wr_ptr[sdp_pkg::WR_ADDR_W-1:0];     // Drop the wrap bit
        assign port.wdata = in_data;

        //////////////////////////////////////////////////////////////////////
        // Pointer and status
        //////////////////////////////////////////////////////////////////////

        always_ff @(posedge clk) begin
                if (reset) begin
                        wr_ptr   <= '0;
                        overflow <= 1'b0;
                end else begin
                        if (push_ok) begin
                                wr_ptr <= wr_ptr + 1'b1;        // Next free word
                        end
                        // A word offered while full is lost, and the next
                        // cycle reports it for exactly one cycle
                        overflow <= in_valid & full;
                end
        end

        // The word counts toward pop eligibility once wr_ptr has moved,
        // which is the edge after it was accepted

endmodule

// File: hdl/sdp_ram.sv
`timescale 1ns/1ps

module sdp_ram (
        input  logic            clk,
        input  logic            reset,
        sdp_port_if.mem         port
);

        //////////////////////////////////////////////////////////////////////
        // Storage
        //////////////////////////////////////////////////////////////////////

        // The array is kept in its wide shape, so a read is a single lookup
        // and a write updates one half of an entry
        sdp_pkg::rd_word_t      mem [2**sdp_pkg::RD_ADDR_W];

        sdp_pkg::rd_addr_t      w_entry;                // Entry that the write lands in
        logic                   w_upper;                // Odd word address goes to the top half

        // Word address 2k is the low half of entry k and 2k+1 is the high half
        assign w_entry = port.waddr[sdp_pkg::WR_ADDR_W-1:1];
        assign w_upper = port.waddr[0];

        //////////////////////////////////////////////////////////////////////
        // Write port
        //////////////////////////////////////////////////////////////////////

        // Contents are undefined after reset, as in the block RAM
        always_ff @(posedge clk) begin
                if (port.we) begin
                        if (w_upper) begin
                                mem[w_entry][sdp_pkg::RD_W-1:sdp_pkg::WR_W] <= port.wdata;
                        end else begin
                                mem[w_entry][sdp_pkg::WR_W-1:0] <= port.wdata;
                        end
                end
        end

        //////////////////////////////////////////////////////////////////////
        // Read port
        //////////////////////////////////////////////////////////////////////

        // The output latch is the only state with a reset value.
        // It follows the macro's set/reset value of all zeros
        always_ff @(posedge clk) begin
                if (reset) begin
                        port.rdata <= '0;
                end else if (port.re) begin
                        // Nonblocking assignment samples the entry before any
                        // write on the same edge, which gives read-first behaviour
                        port.rdata <= mem[port.raddr];
                end
                // Without re the latch keeps the last entry that was read
        end

        // There is no second output register here.
        // Data is ready exactly one cycle after re, straight from the latch

endmodule

// File: hdl/sdp_port_if.sv
`timescale 1ns/1ps

interface sdp_port_if;

        // Write port of the array, one word per cycle
        logic                   we;                     // Store wdata at waddr on this edge
        sdp_pkg::wr_addr_t      waddr;                  // Low bit picks the half of an entry
        sdp_pkg::wr_word_t      wdata;

        // Read port of the array, one entry per cycle
        logic                   re;                     // Latch the entry at raddr on this edge
        sdp_pkg::rd_addr_t      raddr;
        sdp_pkg::rd_word_t      rdata;                  // Valid one cycle after re, held after

        // Producer side drives the whole write port
        modport wr (
                output we,
                output waddr,
                output wdata
        );

        // Consumer side addresses the array and takes the returned entry
        modport rd (
                output re,
                output raddr,
                input  rdata
        );

        // The array itself only listens, apart from the read data
        modport mem (
                input  we, waddr, wdata,
                input  re, raddr,
                output rdata
        );

endinterface

// File: hdl/sdp_pkg.sv
package sdp_pkg;

        //////////////////////////////////////////////////////////////////////
        // Memory geometry
        //////////////////////////////////////////////////////////////////////

        // The write side sees the array as narrow words
        localparam int WR_W      = 32;                  // Width of one pushed word
        localparam int WR_ADDR_W = 10;                  // 1024 words on the write side

        // The read side sees the same bits as wide entries of two words each
        localparam int RD_W      = 64;                  // Width of one popped entry
        localparam int RD_ADDR_W = 9;                   // 512 entries on the read side

        localparam int DEPTH_WORDS = 1024;              // Capacity counted in pushed words

        //////////////////////////////////////////////////////////////////////
        // Vector types
        //////////////////////////////////////////////////////////////////////

        typedef logic [WR_W-1:0]      wr_word_t;        // Data offered by the producer
        typedef logic [RD_W-1:0]      rd_word_t;        // Data handed to the consumer

        typedef logic [WR_ADDR_W-1:0] wr_addr_t;        // Word address into the array
        typedef logic [RD_ADDR_W-1:0] rd_addr_t;        // Entry address into the array

        // Pointers carry one extra bit so that a full array and an empty one
        // can be told apart after the low bits have wrapped
        typedef logic [WR_ADDR_W:0]   wr_ptr_t;         // Counts words
        typedef logic [RD_ADDR_W:0]   rd_ptr_t;         // Counts entries

        // Stored word count, which has to reach the full depth of 1024
        typedef logic [WR_ADDR_W:0]   level_t;

endpackage
